// ==== hdl/tnn_pkg.sv ====
`default_nettype none

package tnn_pkg;

    // ----------------------------------------------------------
    // Widths with a meaning
    // ----------------------------------------------------------
    typedef logic [31:0] wb_data_t;
    typedef logic [7:0]  wb_addr_t;   // Word address into 256 words.
    typedef logic [43:0] feat_vec_t;  // Feature k sits at bits 4k+3 down to 4k.
    typedef logic [2:0]  class_t;

    // ----------------------------------------------------------
    // Wishbone classic signal groups
    // ----------------------------------------------------------
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // Sample i uses words 2i and 2i+1, its class goes to RESULT_BASE+i.
    localparam wb_addr_t RESULT_BASE = 8'd128;

endpackage

`default_nettype wire

// ==== hdl/argmax.sv ====
`timescale 1ns/1ps
`default_nettype none

module argmax #(
    parameter int SIZE       = 7,
    parameter int INDEX_BITS = 3,
    parameter int BITS       = 7
) (
    input  wire logic [SIZE*BITS-1:0] inx,
    output logic [INDEX_BITS-1:0]     outimax
);
    logic [BITS-1:0]       best_val;
    logic [INDEX_BITS-1:0] best_idx;

    // Walks the scores in order, so it scales with SIZE.
    always_comb begin
        best_val = inx[0 +: BITS];
        best_idx = '0;
        for (int i = 1; i < SIZE; i++) begin
            // Strict compare keeps the lower index on a tie.
            if (inx[i*BITS +: BITS] > best_val) begin
                best_val = inx[i*BITS +: BITS];
                best_idx = INDEX_BITS'(i);
            end
        end
    end

    assign outimax = best_idx;

endmodule

`default_nettype wire

// ==== hdl/winewhite_tnn1_tnnpar.sv ====
`timescale 1ns/1ps
`default_nettype none

module winewhite_tnn1_tnnpar #(
    parameter int FEAT_CNT  = 11,
    parameter int FEAT_BITS = 4,
    parameter int CLASS_CNT = 7
) (
    input  wire logic [FEAT_CNT*FEAT_BITS-1:0] features,
    output logic [$clog2(CLASS_CNT)-1:0]       prediction
);
    localparam int HIDDEN_CNT = 40;
    localparam int SUM_BITS   = $clog2(HIDDEN_CNT + 1);
    localparam int SCORE_BITS = SUM_BITS + 1;
    localparam int ACC_BITS   = $clog2(FEAT_CNT + 1) + FEAT_BITS;

    // ----------------------------------------------------------
    // Hidden layer weights as {positive mask, negative mask}
    // ----------------------------------------------------------
    localparam logic [2*FEAT_CNT-1:0] NEURON_MASK [HIDDEN_CNT] = '{
        {11'h090, 11'h303},
        {11'h000, 11'h000},   // Always fires.
        {11'h704, 11'h0F0},
        {11'h021, 11'h0D2},
        {11'h628, 11'h013},
        {11'h040, 11'h08C},
        {11'h0DE, 11'h200},
        {11'h003, 11'h4F0},
        {11'h046, 11'h321},
        {11'h4D0, 11'h109},
        {11'h068, 11'h080},
        {11'h156, 11'h620},
        {11'h0A6, 11'h600},
        {11'h114, 11'h420},
        {11'h20E, 11'h4D0},
        {11'h040, 11'h188},
        {11'h000, 11'h000},
        {11'h021, 11'h192},
        {11'h0CE, 11'h500},
        {11'h042, 11'h23C},
        {11'h423, 11'h0D0},
        {11'h183, 11'h608},
        {11'h507, 11'h068},
        {11'h000, 11'h000},
        {11'h047, 11'h4A8},
        {11'h408, 11'h092},
        {11'h000, 11'h000},   // Forced low by ZERO_MASK.
        {11'h258, 11'h004},
        {11'h000, 11'h000},
        {11'h421, 11'h38E},
        {11'h2B8, 11'h002},
        {11'h4A0, 11'h003},
        {11'h000, 11'h000},
        {11'h000, 11'h000},
        {11'h038, 11'h046},
        {11'h347, 11'h098},
        {11'h202, 11'h0E4},
        {11'h042, 11'h238},
        {11'h006, 11'h400},
        {11'h460, 11'h191}
    };

    // Neurons 26 and 28 are constant zero.
    localparam logic [HIDDEN_CNT-1:0] ZERO_MASK = 40'h00_1400_0000;

    // Per class: neurons counted when set, then neurons counted when clear.
    localparam logic [2*HIDDEN_CNT-1:0] CLASS_MASK [CLASS_CNT] = '{
        {40'h00_1014_8890, 40'h40_0081_0642},
        {40'h60_1158_0880, 40'h04_C081_0400},
        {40'h30_0114_0000, 40'h02_0200_0200},
        {40'h20_8181_8002, 40'h02_0000_0000},
        {40'h00_1040_0000, 40'h02_0021_1100},
        {40'h00_8000_0000, 40'h02_0081_2800},
        {40'h20_0114_2030, 40'h4F_4883_1046}
    };

    localparam int CLASS_BIAS [CLASS_CNT] = '{7, 6, 13, 13, 14, 15, 0};

    logic [FEAT_BITS-1:0]            feature_array [FEAT_CNT];
    logic [HIDDEN_CNT-1:0]           hidden;
    logic [CLASS_CNT*SCORE_BITS-1:0] score_vec;

    for (genvar k = 0; k < FEAT_CNT; k++) begin : g_feat
        assign feature_array[k] = features[k*FEAT_BITS +: FEAT_BITS];
    end

    // ----------------------------------------------------------
    // Ternary neurons
    // ----------------------------------------------------------
    for (genvar j = 0; j < HIDDEN_CNT; j++) begin : g_hidden
        logic [ACC_BITS-1:0] pos_sum;
        logic [ACC_BITS-1:0] neg_sum;

        always_comb begin
            pos_sum = '0;
            neg_sum = '0;
            for (int k = 0; k < FEAT_CNT; k++) begin
                if (NEURON_MASK[j][FEAT_CNT + k]) begin
                    pos_sum = pos_sum + ACC_BITS'(feature_array[k]);
                end
                if (NEURON_MASK[j][k]) begin
                    neg_sum = neg_sum + ACC_BITS'(feature_array[k]);
                end
            end
        end

        assign hidden[j] = (pos_sum >= neg_sum) && !ZERO_MASK[j];   // Ties fire.
    end

    // ----------------------------------------------------------
    // Class scores
    // ----------------------------------------------------------
    for (genvar c = 0; c < CLASS_CNT; c++) begin : g_class
        logic [SUM_BITS-1:0] pop_cnt;

        always_comb begin
            pop_cnt = '0;
            for (int j = 0; j < HIDDEN_CNT; j++) begin
                if (hidden[j] ? CLASS_MASK[c][HIDDEN_CNT + j] : CLASS_MASK[c][j]) begin
                    pop_cnt = pop_cnt + SUM_BITS'(1);
                end
            end
        end

        assign score_vec[c*SCORE_BITS +: SCORE_BITS] =
            {pop_cnt, 1'b0} + SCORE_BITS'(CLASS_BIAS[c]);   // Twice the count plus bias.
    end

    argmax #(
        .SIZE       (CLASS_CNT),
        .INDEX_BITS ($clog2(CLASS_CNT)),
        .BITS       (SCORE_BITS)
    ) argmax_i (
        .inx     (score_vec),
        .outimax (prediction)
    );

endmodule

`default_nettype wire

// ==== hdl/sample_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_ram #(
    parameter int ADDR_BITS = 8
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire tnn_pkg::wb_req_t req,
    output tnn_pkg::wb_rsp_t     rsp
);
    import tnn_pkg::*;

    wb_data_t mem [2**ADDR_BITS];
    wb_data_t rd_data;
    logic     ack;
    logic     access;

    assign access = req.cyc && req.stb && !ack;   // One access per strobe.

    always_ff @(posedge clk) begin
        if (access && req.we) begin
            mem[req.adr[ADDR_BITS-1:0]] <= req.dat;
        end
        if (access) begin
            rd_data <= mem[req.adr[ADDR_BITS-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= access;   // High for one cycle only.
        end
    end

    assign rsp = '{ack: ack, dat: rd_data};

endmodule

`default_nettype wire

// ==== hdl/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire tnn_pkg::wb_req_t m0_req,
    input  wire tnn_pkg::wb_req_t m1_req,
    output tnn_pkg::wb_rsp_t      m0_rsp,
    output tnn_pkg::wb_rsp_t      m1_rsp,
    output tnn_pkg::wb_req_t      s_req,
    input  wire tnn_pkg::wb_rsp_t s_rsp
);
    import tnn_pkg::*;

    logic    owner;      // Master holding the grant.
    logic    last_win;   // Master served by the previous grant.
    logic    active;
    logic    pick;
    wb_req_t sel_req;

    // Both asking means the one not served last goes first.
    assign pick    = (m0_req.cyc && m1_req.cyc) ? !last_win : m1_req.cyc;
    assign sel_req = owner ? m1_req : m0_req;

    // ----------------------------------------------------------
    // Grant tracking
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            owner    <= 1'b0;
            last_win <= 1'b1;
        end else if (!active) begin
            if (m0_req.cyc || m1_req.cyc) begin
                active <= 1'b1;
                owner  <= pick;
            end
        end else if (!sel_req.cyc) begin
            active   <= 1'b0;   // Owner ended its cycle.
            last_win <= owner;
        end
    end

    // ----------------------------------------------------------
    // Routing
    // ----------------------------------------------------------
    assign s_req  = active ? sel_req : '0;
    assign m0_rsp = '{ack: active && !owner && s_rsp.ack, dat: s_rsp.dat};
    assign m1_rsp = '{ack: active && owner && s_rsp.ack, dat: s_rsp.dat};

endmodule

`default_nettype wire

// ==== hdl/batch_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module batch_classifier #(
    parameter int FEAT_CNT  = 11,
    parameter int FEAT_BITS = 4
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    input  wire logic [6:0]        sample_cnt,
    output logic                   busy,
    output tnn_pkg::wb_req_t       bus_req,
    input  wire tnn_pkg::wb_rsp_t  bus_rsp,
    output tnn_pkg::feat_vec_t     feat,
    input  wire tnn_pkg::class_t   prediction
);
    import tnn_pkg::*;

    localparam int HI_BITS = FEAT_CNT*FEAT_BITS - $bits(wb_data_t);

    typedef enum logic [2:0] {
        st_idle,
        st_read_lo,
        st_read_hi,
        st_classify,
        st_write_res,
        st_next
    } state_t;

    state_t    state;
    logic      req_on;
    logic [5:0] idx;
    logic [6:0] remaining;
    wb_data_t  lo_word;
    feat_vec_t feat_q;
    class_t    result;
    wb_addr_t  adr;

    always_comb begin
        case (state)
            st_read_hi:   adr = {1'b0, idx, 1'b1};
            st_write_res: adr = RESULT_BASE + wb_addr_t'(idx);
            default:      adr = {1'b0, idx, 1'b0};
        endcase
    end

    assign bus_req = '{cyc: req_on, stb: req_on, we: state == st_write_res,
                       adr: adr, dat: wb_data_t'(result)};
    assign feat    = feat_q;

    // ----------------------------------------------------------
    // Sample sequencing
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            req_on    <= 1'b0;
            busy      <= 1'b0;
            idx       <= '0;
            remaining <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        busy      <= 1'b1;
                        idx       <= '0;
                        remaining <= sample_cnt;
                        state     <= st_next;
                    end
                end
                st_read_lo, st_read_hi, st_write_res: begin
                    if (!req_on) begin
                        req_on <= 1'b1;   // Raised one cycle after the last release.
                    end else if (bus_rsp.ack) begin
                        req_on <= 1'b0;
                        case (state)
                            st_read_lo: state <= st_read_hi;
                            st_read_hi: state <= st_classify;
                            default: begin
                                idx       <= idx + 6'd1;
                                remaining <= remaining - 7'd1;
                                state     <= st_next;
                            end
                        endcase
                    end
                end
                st_classify: state <= st_write_res;
                default: begin
                    if (remaining == '0) begin
                        busy  <= 1'b0;
                        state <= st_idle;
                    end else begin
                        state <= st_read_lo;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_read_lo && req_on && bus_rsp.ack) begin
            lo_word <= bus_rsp.dat;
        end
        if (state == st_read_hi && req_on && bus_rsp.ack) begin
            feat_q <= {bus_rsp.dat[HI_BITS-1:0], lo_word};
        end
        if (state == st_classify) begin
            result <= prediction;   // Network output for feat_q.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tnn_accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tnn_accel_top #(
    parameter int FEAT_CNT  = 11,
    parameter int FEAT_BITS = 4,
    parameter int CLASS_CNT = 7,
    parameter int ADDR_BITS = 8
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire tnn_pkg::wb_req_t host_req,
    output tnn_pkg::wb_rsp_t      host_rsp,
    input  wire logic             start,
    input  wire logic [6:0]       sample_cnt,
    output logic                  busy
);
    import tnn_pkg::*;

    wb_req_t   cls_req;
    wb_rsp_t   cls_rsp;
    wb_req_t   ram_req;
    wb_rsp_t   ram_rsp;
    feat_vec_t feat;
    class_t    prediction;

    // Host is master 0, the classifier master 1.
    wb_arbiter wb_arbiter_i (
        .clk    (clk),
        .rst    (rst),
        .m0_req (host_req),
        .m1_req (cls_req),
        .m0_rsp (host_rsp),
        .m1_rsp (cls_rsp),
        .s_req  (ram_req),
        .s_rsp  (ram_rsp)
    );

    sample_ram #(.ADDR_BITS(ADDR_BITS)) sample_ram_i (
        .clk (clk),
        .rst (rst),
        .req (ram_req),
        .rsp (ram_rsp)
    );

    batch_classifier #(
        .FEAT_CNT  (FEAT_CNT),
        .FEAT_BITS (FEAT_BITS)
    ) batch_classifier_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .sample_cnt (sample_cnt),
        .busy       (busy),
        .bus_req    (cls_req),
        .bus_rsp    (cls_rsp),
        .feat       (feat),
        .prediction (prediction)
    );

    winewhite_tnn1_tnnpar #(
        .FEAT_CNT  (FEAT_CNT),
        .FEAT_BITS (FEAT_BITS),
        .CLASS_CNT (CLASS_CNT)
    ) tnn_i (
        .features   (feat),
        .prediction (prediction)
    );

endmodule

`default_nettype wire

// ==== dv/tnn_golden.svh ====
`ifndef TNN_GOLDEN_SVH
`define TNN_GOLDEN_SVH

// ------------------------------------------------------------
// Reference weights, one entry per hidden neuron
// ------------------------------------------------------------
// Bit k of a mask selects feature k.
localparam logic [10:0] POS_MASK [40] = '{
    11'h090, 11'h000, 11'h704, 11'h021, 11'h628, 11'h040, 11'h0DE, 11'h003,
    11'h046, 11'h4D0, 11'h068, 11'h156, 11'h0A6, 11'h114, 11'h20E, 11'h040,
    11'h000, 11'h021, 11'h0CE, 11'h042, 11'h423, 11'h183, 11'h507, 11'h000,
    11'h047, 11'h408, 11'h000, 11'h258, 11'h000, 11'h421, 11'h2B8, 11'h4A0,
    11'h000, 11'h000, 11'h038, 11'h347, 11'h202, 11'h042, 11'h006, 11'h460
};

localparam logic [10:0] NEG_MASK [40] = '{
    11'h303, 11'h000, 11'h0F0, 11'h0D2, 11'h013, 11'h08C, 11'h200, 11'h4F0,
    11'h321, 11'h109, 11'h080, 11'h620, 11'h600, 11'h420, 11'h4D0, 11'h188,
    11'h000, 11'h192, 11'h500, 11'h23C, 11'h0D0, 11'h608, 11'h068, 11'h000,
    11'h4A8, 11'h092, 11'h000, 11'h004, 11'h000, 11'h38E, 11'h002, 11'h003,
    11'h000, 11'h000, 11'h046, 11'h098, 11'h0E4, 11'h238, 11'h400, 11'h191
};

localparam logic [39:0] STUCK_LOW = (40'd1 << 26) | (40'd1 << 28);   // Constant neurons.

// Neurons that add to a class score when they fire, and when they stay low.
localparam logic [39:0] SET_MASK [7] = '{
    40'h00_1014_8890, 40'h60_1158_0880, 40'h30_0114_0000, 40'h20_8181_8002,
    40'h00_1040_0000, 40'h00_8000_0000, 40'h20_0114_2030
};

localparam logic [39:0] CLR_MASK [7] = '{
    40'h40_0081_0642, 40'h04_C081_0400, 40'h02_0200_0200, 40'h02_0000_0000,
    40'h02_0021_1100, 40'h02_0081_2800, 40'h4F_4883_1046
};

localparam int BIAS [7] = '{7, 6, 13, 13, 14, 15, 0};

function automatic logic [2:0] golden_class(input logic [43:0] f);
    logic [39:0] fired;
    int          pos;
    int          neg;
    int          score;
    int          best;
    int          best_c;
    fired  = '0;
    best   = 0;
    best_c = 0;
    for (int j = 0; j < 40; j++) begin
        pos = 0;
        neg = 0;
        for (int k = 0; k < 11; k++) begin
            if (POS_MASK[j][k]) pos = pos + int'(f[4*k +: 4]);
            if (NEG_MASK[j][k]) neg = neg + int'(f[4*k +: 4]);
        end
        fired[j] = (pos >= neg) && !STUCK_LOW[j];
    end
    for (int c = 0; c < 7; c++) begin
        score = 2 * $countones((fired & SET_MASK[c]) | (~fired & CLR_MASK[c])) + BIAS[c];
        if (c == 0 || score > best) begin   // Lowest class wins a tie.
            best   = score;
            best_c = c;
        end
    end
    return 3'(best_c);
endfunction

`endif

// ==== dv/tb_tnn_accel.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tnn_accel;
    import tnn_pkg::*;

    `include "tnn_golden.svh"

    localparam int N_SAMPLES       = 24;
    localparam int WATCHDOG_CYCLES = 400 * (N_SAMPLES + 4 + 1) + 10000;

    logic       clk;
    logic       rst;
    wb_req_t    host_req;
    wb_rsp_t    host_rsp;
    logic       start;
    logic [6:0] sample_cnt;
    logic       busy;

    string     tc_name [N_SAMPLES];
    feat_vec_t tc_feat [N_SAMPLES];
    class_t    tc_exp  [N_SAMPLES];
    int        tc_cnt;
    int        err_cnt;
    int        check_cnt;
    int        busy_steps;

    tnn_accel_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .start      (start),
        .sample_cnt (sample_cnt),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic wb_data_t fill_word(input wb_addr_t a);
        return {~a, a, a ^ 8'h96, a + 8'h01};
    endfunction

    function automatic wb_data_t marker_word(input wb_addr_t a);
        return {8'hC3, a, ~a, 8'h7E};   // Upper bits set, never a valid result.
    endfunction

    function automatic wb_data_t sample_word(input int i, input logic hi);
        return hi ? {20'h0, tc_feat[i][43:32]} : tc_feat[i][31:0];
    endfunction

    task automatic add_entry(input string name, input feat_vec_t f);
        tc_name[tc_cnt] = name;
        tc_feat[tc_cnt] = f;
        tc_exp[tc_cnt]  = golden_class(f);
        tc_cnt++;
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [31:0] lo;
        rnd = 32'h92f8;
        add_entry("all_zero", 44'h000_0000_0000);
        add_entry("all_fifteen", 44'hFFF_FFFF_FFFF);
        add_entry("feat0_max", 44'h000_0000_000F);
        add_entry("feat3_max", 44'h000_0000_F000);
        add_entry("feat7_max", 44'h000_F000_0000);
        add_entry("feat10_max", 44'hF00_0000_0000);
        add_entry("ramp_up", 44'hA98_7654_3210);
        add_entry("ramp_down", 44'h012_3456_789A);
        add_entry("checker", 44'hF0F_0F0F_0F0F);
        add_entry("mid_level", 44'h888_8888_8888);
        while (tc_cnt < N_SAMPLES) begin
            rnd = xorshift32(rnd);
            lo  = rnd;
            rnd = xorshift32(rnd);
            add_entry($sformatf("random_%0d", tc_cnt), {rnd[11:0], lo});
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // One Wishbone classic access from the host, then one idle cycle.
    task automatic bus_access(input logic is_write, input wb_addr_t adr, input wb_data_t wdat,
                              output wb_data_t rdat);
        host_req = '{cyc: 1'b1, stb: 1'b1, we: is_write, adr: adr, dat: wdat};
        do begin
            step();
        end while (!host_rsp.ack);
        rdat     = host_rsp.dat;
        host_req = '0;
        step();
    endtask

    task automatic write_word(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic check_word(input string name, input wb_addr_t adr, input wb_data_t exp);
        wb_data_t got;
        bus_access(1'b0, adr, '0, got);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch in %s at word %0d: expected %h, actual %h", name, adr, exp, got);
        end
    endtask

    task automatic check_results(input int cnt);
        for (int i = 0; i < 128; i++) begin
            if (i < cnt) begin
                check_word(tc_name[i], RESULT_BASE + wb_addr_t'(i), {29'h0, tc_exp[i]});
            end else begin
                check_word("result_marker", RESULT_BASE + wb_addr_t'(i),
                           marker_word(RESULT_BASE + wb_addr_t'(i)));
            end
        end
    endtask

    task automatic prefill_results();
        for (int i = 0; i < 128; i++) begin
            write_word(RESULT_BASE + wb_addr_t'(i), marker_word(RESULT_BASE + wb_addr_t'(i)));
        end
    endtask

    // Starts a batch and waits for busy to fall, with optional host traffic.
    task automatic run_batch(input int cnt, input logic with_reads, input logic restart);
        int reads;
        int w;
        reads      = 0;
        w          = 0;
        busy_steps = 0;
        sample_cnt = 7'(cnt);
        start      = 1'b1;
        step();
        start      = 1'b0;
        check_cnt++;
        if (busy !== 1'b1) begin
            err_cnt++;
            $display("busy did not rise one cycle after start");
        end
        if (restart) begin
            repeat (3) step();
            sample_cnt = 7'(N_SAMPLES);   // A restart would pick this count up.
            start      = 1'b1;
            step();
            start      = 1'b0;
        end
        while (busy) begin
            if (with_reads) begin
                check_word("sample_during_batch", wb_addr_t'(w), sample_word(w / 2, w[0]));
                w = (w + 1) % (2 * N_SAMPLES);
                if (busy) begin
                    reads = reads + 1;   // Served while the classifier still runs.
                end
            end else begin
                step();
                busy_steps = busy_steps + 1;
            end
        end
        if (with_reads && reads == 0) begin
            err_cnt++;
            $display("No host read completed while the batch was running");
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        rst        = 1'b1;
        host_req   = '0;
        start      = 1'b0;
        sample_cnt = '0;
        tc_cnt     = 0;
        err_cnt    = 0;
        check_cnt  = 0;
        busy_steps = 0;
        build_table();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        step();

        check_cnt++;
        if (busy !== 1'b0) begin
            err_cnt++;
            $display("busy is not low after reset");
        end
        for (int a = 0; a < 128; a++) begin
            write_word(wb_addr_t'(a), fill_word(wb_addr_t'(a)));
        end
        for (int a = 0; a < 128; a++) begin
            check_word("mem_readback", wb_addr_t'(a), fill_word(wb_addr_t'(a)));
        end

        for (int i = 0; i < N_SAMPLES; i++) begin
            write_word(wb_addr_t'(2 * i), sample_word(i, 1'b0));
            write_word(wb_addr_t'(2 * i + 1), sample_word(i, 1'b1));
        end
        prefill_results();
        run_batch(N_SAMPLES, 1'b1, 1'b0);   // Full batch with host reads in parallel.
        check_results(N_SAMPLES);

        prefill_results();
        run_batch(4, 1'b0, 1'b1);
        check_results(4);

        prefill_results();
        run_batch(0, 1'b0, 1'b0);
        check_cnt++;
        if (busy_steps != 1) begin
            err_cnt++;
            $display("busy stayed high for %0d cycles in an empty batch, expected 1", busy_steps);
        end
        step();
        check_cnt++;
        if (busy !== 1'b0) begin
            err_cnt++;
            $display("busy is still high after an empty batch");
        end
        check_results(0);

        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+dv
hdl/tnn_pkg.sv
hdl/argmax.sv
hdl/winewhite_tnn1_tnnpar.sv
hdl/sample_ram.sv
hdl/wb_arbiter.sv
hdl/batch_classifier.sv
hdl/tnn_accel_top.sv
dv/tb_tnn_accel.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_tnn_accel -f list.f -o tb_tnn_accel; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_tnn_accel > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
